/* build.f */
+incdir+design
design/rv_pkg.sv
design/rv_fwd_if.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_hazard.sv
design/rv_pipeline.sv
tests/tb_rv_pipeline.sv

/* run.sh */
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_rv_pipeline -o tb_rv_pipeline
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_rv_pipeline)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

/* tests/tb_rv_pipeline.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_pipeline;

    localparam logic [31:0] poison_addr = 32'h0000_03f0;
    localparam logic [31:0] end_addr    = 32'h0000_03fc;
    localparam int          max_cycles  = 3000;

    logic                clk;
    logic                i_arst_n;
    logic [`RV_XLEN-1:0] i_imem_data;
    logic                i_imem_resp;
    logic [`RV_XLEN-1:0] i_dmem_rdata;
    logic                i_dmem_resp;
    logic [`RV_XLEN-1:0] o_imem_addr;
    logic                o_imem_rd;
    logic [`RV_XLEN-1:0] o_dmem_addr;
    logic [`RV_XLEN-1:0] o_dmem_wdata;
    logic                o_dmem_rd;
    logic                o_dmem_wr;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    int          prog_len;
    int          checks;
    int          errors;
    int          delay_left;
    int          cycles;
    int          poison_got;
    int          poison_exp;
    bit          pending;
    bit          done;

    rv_pipeline i_dut (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_imem_data  (i_imem_data),
        .i_imem_resp  (i_imem_resp),
        .i_dmem_rdata (i_dmem_rdata),
        .i_dmem_resp  (i_dmem_resp),
        .o_imem_addr  (o_imem_addr),
        .o_imem_rd    (o_imem_rd),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_rd    (o_dmem_rd),
        .o_dmem_wr    (o_dmem_wr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // RV32I instruction formats
    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] op_imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] op_reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic sw_expecting(input logic [4:0] src, input logic [31:0] addr,
                                input logic [31:0] value);
        emit(store_word(src, 5'd0, addr[11:0]));
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    // Branch skips its shadow store when taken
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                               input bit taken, input logic [4:0] src, input logic [31:0] value);
        emit(branch_word(f3, rs1, rs2, 13'd8));
        emit(store_word(src, 5'd0, poison_addr[11:0]));
        if (!taken) begin
            exp_addr.push_back(poison_addr);
            exp_data.push_back(value);
            poison_exp++;
        end
    endtask

    task automatic load_program();
        emit(lui_word(5'd1, 20'h12345));
        emit(op_imm_word(3'b000, 5'd2, 5'd1, 12'h678));
        emit(op_imm_word(3'b100, 5'd3, 5'd2, 12'hfff));
        emit(op_reg_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(op_imm_word(3'b101, 5'd5, 5'd4, 12'h404));
        emit(op_imm_word(3'b101, 5'd6, 5'd4, 12'h008));
        emit(op_reg_word(7'h00, 3'b110, 5'd7, 5'd5, 5'd6));
        emit(op_reg_word(7'h00, 3'b010, 5'd8, 5'd5, 5'd6));
        emit(op_reg_word(7'h00, 3'b011, 5'd9, 5'd5, 5'd6));
        emit(op_reg_word(7'h20, 3'b101, 5'd10, 5'd4, 5'd8));
        emit(op_reg_word(7'h00, 3'b111, 5'd11, 5'd7, 5'd2));
        emit(op_reg_word(7'h00, 3'b000, 5'd12, 5'd11, 5'd8));
        sw_expecting(5'd12, 32'h124, 32'h1030_5659);
        sw_expecting(5'd2, 32'h100, 32'h1234_5678);
        sw_expecting(5'd3, 32'h104, 32'hedcb_a987);
        sw_expecting(5'd4, 32'h108, 32'hdb97_5987);
        sw_expecting(5'd5, 32'h10c, 32'hfdb9_7598);
        sw_expecting(5'd6, 32'h110, 32'h00db_9759);
        sw_expecting(5'd7, 32'h114, 32'hfdfb_f7d9);
        sw_expecting(5'd8, 32'h118, 32'h0000_0001);
        sw_expecting(5'd9, 32'h11c, 32'h0000_0000);
        sw_expecting(5'd10, 32'h120, 32'hedcb_acc3);
        // Load-use pair
        emit(load_word(5'd13, 5'd0, 12'h100));
        emit(op_reg_word(7'h00, 3'b000, 5'd14, 5'd13, 5'd8));
        sw_expecting(5'd14, 32'h128, 32'h1234_5679);
        // x5 is negative, x6 positive
        branch_case(3'b000, 5'd6, 5'd6, 1'b1, 5'd1, '0);
        branch_case(3'b000, 5'd5, 5'd6, 1'b0, 5'd2, 32'h1234_5678);
        branch_case(3'b001, 5'd5, 5'd6, 1'b1, 5'd1, '0);
        branch_case(3'b001, 5'd6, 5'd6, 1'b0, 5'd3, 32'hedcb_a987);
        branch_case(3'b100, 5'd5, 5'd6, 1'b1, 5'd1, '0);
        branch_case(3'b100, 5'd6, 5'd5, 1'b0, 5'd4, 32'hdb97_5987);
        branch_case(3'b101, 5'd6, 5'd5, 1'b1, 5'd1, '0);
        branch_case(3'b101, 5'd5, 5'd6, 1'b0, 5'd5, 32'hfdb9_7598);
        branch_case(3'b110, 5'd6, 5'd5, 1'b1, 5'd1, '0);
        branch_case(3'b110, 5'd5, 5'd6, 1'b0, 5'd6, 32'h00db_9759);
        branch_case(3'b111, 5'd5, 5'd6, 1'b1, 5'd1, '0);
        branch_case(3'b111, 5'd6, 5'd5, 1'b0, 5'd7, 32'hfdfb_f7d9);
        sw_expecting(5'd1, end_addr, 32'h1234_5000);
        // Park on a self loop
        emit(branch_word(3'b000, 5'd0, 5'd0, 13'd0));
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic require(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic answer_request();
        logic [7:0] idx;
        idx = o_dmem_addr[9:2];
        if (o_dmem_wr) begin
            dmem[idx] = o_dmem_wdata;
            got_addr.push_back(o_dmem_addr);
            got_data.push_back(o_dmem_wdata);
            if (o_dmem_addr == poison_addr) begin
                poison_got++;
            end
            if (o_dmem_addr == end_addr) begin
                done = 1'b1;
            end
        end
        i_dmem_rdata = dmem[idx];
        i_dmem_resp  = 1'b1;
    endtask

    // Instruction side answers at once, data side after 0 to 3 cycles
    task automatic serve_memories();
        forever begin
            @(posedge clk);
            #1;
            i_imem_data = imem[o_imem_addr[9:2]];
            i_imem_resp = 1'b1;
            i_dmem_resp = 1'b0;
            if (o_dmem_rd || o_dmem_wr) begin
                require(!(o_dmem_rd && o_dmem_wr), "Read and write requested together");
                if (pending) begin
                    compare_word("o_dmem_addr while waiting", o_dmem_addr, req_addr);
                    compare_word("o_dmem_wdata while waiting", o_dmem_wdata, req_wdata);
                end else begin
                    pending    = 1'b1;
                    delay_left = $urandom_range(3, 0);
                    req_addr   = o_dmem_addr;
                    req_wdata  = o_dmem_wdata;
                end
                if (delay_left == 0) begin
                    answer_request();
                    pending = 1'b0;
                end else begin
                    delay_left--;
                end
            end
        end
    endtask

    task automatic check_reset_outputs();
        compare_word("o_imem_addr", o_imem_addr, `RV_RESET_PC);
        require(!o_dmem_rd && !o_dmem_wr, "Data request raised during or right after reset");
    endtask

    initial begin
        void'($urandom(98));
        i_arst_n     = 1'b0;
        i_imem_data  = '0;
        i_imem_resp  = 1'b0;
        i_dmem_rdata = '0;
        i_dmem_resp  = 1'b0;
        prog_len     = 0;
        checks       = 0;
        errors       = 0;
        delay_left   = 0;
        poison_got   = 0;
        poison_exp   = 0;
        pending      = 1'b0;
        done         = 1'b0;
        for (int n = 0; n < 256; n++) begin
            imem[n] = '0;
            dmem[n] = 32'hd00d_0000 ^ (32'(n) << 2);
        end
        load_program();

        fork
            serve_memories();
        join_none

        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
            #1;
            check_reset_outputs();
        end
        i_arst_n = 1'b1;
        #5;
        check_reset_outputs();
        @(posedge clk);
        #1;
        require(!o_dmem_rd && !o_dmem_wr, "Data request raised at the first edge after reset");

        // Fetch request stays up for the whole run
        cycles = 0;
        while (!done && cycles < max_cycles) begin
            @(negedge clk);
            compare_word("o_imem_rd", 32'(o_imem_rd), 32'd1);
            cycles++;
        end
        require(done, "Timed out waiting for the final store");

        compare_word("store count", 32'(got_addr.size()), 32'(exp_addr.size()));
        compare_word("stores to poison address", 32'(poison_got), 32'(poison_exp));
        for (int n = 0; n < exp_addr.size() && n < got_addr.size(); n++) begin
            compare_word($sformatf("o_dmem_addr of store %0d", n), got_addr[n], exp_addr[n]);
            compare_word($sformatf("o_dmem_wdata of store %0d", n), got_data[n], exp_data[n]);
        end

        $display("Run finished: %0d checks, %0d errors, %0d stores",
                 checks, errors, got_addr.size());
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* design/rv_pipeline.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_pipeline (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic [`RV_XLEN-1:0] i_imem_data,
    input  logic                i_imem_resp,
    input  logic [`RV_XLEN-1:0] i_dmem_rdata,
    input  logic                i_dmem_resp,
    output logic [`RV_XLEN-1:0] o_imem_addr,
    output logic                o_imem_rd,
    output logic [`RV_XLEN-1:0] o_dmem_addr,
    output logic [`RV_XLEN-1:0] o_dmem_wdata,
    output logic                o_dmem_rd,
    output logic                o_dmem_wr
);

    logic [`RV_XLEN-1:0]  pc_q;
    logic [`RV_XLEN-1:0]  id_instr, id_pc, id_imm, id_rs1_val, id_rs2_val;
    logic [`RV_REG_W-1:0] id_rs1, id_rs2, id_rd;
    rv_pkg::ctrl_t        id_ctrl;
    logic [`RV_XLEN-1:0]  ex_pc, ex_imm, ex_rs1_val, ex_rs2_val;
    logic [`RV_REG_W-1:0] ex_rs1, ex_rs2, ex_rd;
    rv_pkg::ctrl_t        ex_ctrl;
    logic [`RV_XLEN-1:0]  ex_result, ex_store_data, ex_target;
    logic                 ex_taken;
    logic [`RV_XLEN-1:0]  mem_alu, mem_store, mem_imm, mem_value;
    logic [`RV_REG_W-1:0] mem_rd;
    rv_pkg::ctrl_t        mem_ctrl;
    logic [`RV_XLEN-1:0]  wb_result, wb_load, wb_value;
    logic [`RV_REG_W-1:0] wb_rd;
    rv_pkg::ctrl_t        wb_ctrl;
    logic                 rf_we;
    logic                 load_pc, load_id, load_ex, load_mem, load_wb;
    logic                 flush_id, flush_ex, bubble_mem;

    rv_fwd_if fwd ();

    assign o_imem_addr = pc_q;
    assign o_imem_rd   = 1'b1;

    // Control state, cleared to bubbles
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q     <= `RV_RESET_PC;
            id_instr <= '0;
            ex_ctrl  <= '0;
            mem_ctrl <= '0;
            wb_ctrl  <= '0;
        end else begin
            if (load_pc) begin
                pc_q <= ex_taken ? ex_target : pc_q + `RV_XLEN'(4);
            end
            if (load_id) begin
                id_instr <= flush_id ? '0 : i_imem_data;
            end
            if (load_ex) begin
                ex_ctrl <= flush_ex ? '0 : id_ctrl;
            end
            if (load_mem) begin
                mem_ctrl <= bubble_mem ? '0 : ex_ctrl;
            end
            if (load_wb) begin
                wb_ctrl <= mem_ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_id) begin
            id_pc <= pc_q;
        end
        if (load_ex) begin
            ex_pc      <= id_pc;
            ex_rs1     <= id_rs1;
            ex_rs2     <= id_rs2;
            ex_rd      <= id_rd;
            ex_imm     <= id_imm;
            ex_rs1_val <= id_rs1_val;
            ex_rs2_val <= id_rs2_val;
        end else if (rf_we) begin
            // Held EX operands pick up the write retiring from WB
            if (wb_rd == ex_rs1) begin
                ex_rs1_val <= wb_value;
            end
            if (wb_rd == ex_rs2) begin
                ex_rs2_val <= wb_value;
            end
        end
        if (load_mem) begin
            mem_rd    <= ex_rd;
            mem_alu   <= ex_result;
            mem_store <= ex_store_data;
            mem_imm   <= ex_imm;
        end
        if (load_wb) begin
            wb_rd     <= mem_rd;
            wb_result <= mem_value;
            wb_load   <= i_dmem_rdata;
        end
    end

    rv_decode u_decode (
        .i_instr (id_instr),
        .o_ctrl  (id_ctrl),
        .o_rs1   (id_rs1),
        .o_rs2   (id_rs2),
        .o_rd    (id_rd),
        .o_imm   (id_imm)
    );

    assign rf_we = wb_ctrl.reg_write && load_wb && wb_rd != '0;

    rv_regfile u_regfile (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_we      (rf_we),
        .i_waddr   (wb_rd),
        .i_wdata   (wb_value),
        .i_raddr_a (id_rs1),
        .i_raddr_b (id_rs2),
        .o_rdata_a (id_rs1_val),
        .o_rdata_b (id_rs2_val)
    );

    rv_execute u_execute (
        .i_ctrl       (ex_ctrl),
        .i_pc         (ex_pc),
        .i_rs1        (ex_rs1),
        .i_rs2        (ex_rs2),
        .i_rs1_val    (ex_rs1_val),
        .i_rs2_val    (ex_rs2_val),
        .i_imm        (ex_imm),
        .fwd          (fwd),
        .o_result     (ex_result),
        .o_store_data (ex_store_data),
        .o_taken      (ex_taken),
        .o_target     (ex_target)
    );

    rv_hazard u_hazard (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_ex_rs1     (ex_rs1),
        .i_ex_rs2     (ex_rs2),
        .i_ex_ctrl    (ex_ctrl),
        .i_taken      (ex_taken),
        .i_imem_resp  (i_imem_resp),
        .i_dmem_req   (o_dmem_rd || o_dmem_wr),
        .i_dmem_resp  (i_dmem_resp),
        .fwd          (fwd),
        .o_load_pc    (load_pc),
        .o_load_id    (load_id),
        .o_load_ex    (load_ex),
        .o_load_mem   (load_mem),
        .o_load_wb    (load_wb),
        .o_flush_id   (flush_id),
        .o_flush_ex   (flush_ex),
        .o_bubble_mem (bubble_mem)
    );

    // MEM stage and data port
    assign mem_value    = (mem_ctrl.wb_sel == rv_pkg::wb_imm) ? mem_imm : mem_alu;
    assign o_dmem_addr  = {mem_alu[`RV_XLEN-1:2], 2'b00};
    assign o_dmem_wdata = mem_store;
    assign o_dmem_rd    = mem_ctrl.mem_read;
    assign o_dmem_wr    = mem_ctrl.mem_write;

    assign wb_value = (wb_ctrl.wb_sel == rv_pkg::wb_load) ? wb_load : wb_result;

    assign fwd.mem_rd      = mem_rd;
    assign fwd.mem_wr      = mem_ctrl.reg_write;
    assign fwd.mem_is_load = mem_ctrl.mem_read;
    assign fwd.mem_value   = mem_value;
    assign fwd.wb_rd       = wb_rd;
    assign fwd.wb_wr       = wb_ctrl.reg_write;
    assign fwd.wb_value    = wb_value;

    // Data request holds until answered
    a_dmem_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_dmem_rd || o_dmem_wr) && !i_dmem_resp |=>
        $stable(o_dmem_addr) && $stable(o_dmem_wdata) &&
        $stable(o_dmem_rd) && $stable(o_dmem_wr));

endmodule

/* design/rv_hazard.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_hazard (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic [`RV_REG_W-1:0] i_ex_rs1,
    input  logic [`RV_REG_W-1:0] i_ex_rs2,
    input  rv_pkg::ctrl_t        i_ex_ctrl,
    input  logic                 i_taken,
    input  logic                 i_imem_resp,
    input  logic                 i_dmem_req,
    input  logic                 i_dmem_resp,
    rv_fwd_if.exe                fwd,
    output logic                 o_load_pc,
    output logic                 o_load_id,
    output logic                 o_load_ex,
    output logic                 o_load_mem,
    output logic                 o_load_wb,
    output logic                 o_flush_id,
    output logic                 o_flush_ex,
    output logic                 o_bubble_mem
);

    logic mem_wait;
    logic raw_load;
    logic load_use;
    logic bubbled_q;

    // Either memory still owes an answer
    assign mem_wait = !i_imem_resp || (i_dmem_req && !i_dmem_resp);

    // EX needs a value the load in MEM has not returned
    assign raw_load = fwd.mem_is_load && fwd.mem_rd != '0 &&
                      ((i_ex_ctrl.uses_rs1 && i_ex_rs1 == fwd.mem_rd) ||
                       (i_ex_ctrl.uses_rs2 && i_ex_rs2 == fwd.mem_rd));
    assign load_use = raw_load && !bubbled_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            bubbled_q <= 1'b0;
        end else if (!mem_wait) begin
            bubbled_q <= load_use;
        end
    end

    assign o_load_mem   = !mem_wait;
    assign o_load_wb    = !mem_wait;
    assign o_load_pc    = !mem_wait && !load_use;
    assign o_load_id    = o_load_pc;
    assign o_load_ex    = o_load_pc;
    assign o_bubble_mem = load_use;

    // Branch outcome only counts once its operands are valid
    assign o_flush_id = i_taken && o_load_pc;
    assign o_flush_ex = o_flush_id;

    // Flush never lands on a frozen front end, and EX is empty afterwards
    a_flush_clean: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_flush_id |-> !mem_wait ##1 !i_taken);

endmodule

/* design/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_execute (
    input  rv_pkg::ctrl_t        i_ctrl,
    input  logic [`RV_XLEN-1:0]  i_pc,
    input  logic [`RV_REG_W-1:0] i_rs1,
    input  logic [`RV_REG_W-1:0] i_rs2,
    input  logic [`RV_XLEN-1:0]  i_rs1_val,
    input  logic [`RV_XLEN-1:0]  i_rs2_val,
    input  logic [`RV_XLEN-1:0]  i_imm,
    rv_fwd_if.exe                fwd,
    output logic [`RV_XLEN-1:0]  o_result,
    output logic [`RV_XLEN-1:0]  o_store_data,
    output logic                 o_taken,
    output logic [`RV_XLEN-1:0]  o_target
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_b;
    logic                cmp_hit;

    // MEM beats WB; a load in MEM has no data yet
    function automatic logic [`RV_XLEN-1:0] fwd_value(
        input logic [`RV_REG_W-1:0] idx,
        input logic [`RV_XLEN-1:0]  rf_val
    );
        logic [`RV_XLEN-1:0] val;
        val = rf_val;
        if (idx != '0) begin
            if (fwd.mem_wr && !fwd.mem_is_load && fwd.mem_rd == idx) begin
                val = fwd.mem_value;
            end else if (fwd.wb_wr && fwd.wb_rd == idx) begin
                val = fwd.wb_value;
            end
        end
        return val;
    endfunction

    always_comb begin
        op_a = fwd_value(i_rs1, i_rs1_val);
        op_b = fwd_value(i_rs2, i_rs2_val);
    end

    assign alu_b = i_ctrl.use_imm ? i_imm : op_b;

    always_comb begin
        o_result = '0;
        case (i_ctrl.alu_op)
            rv_pkg::alu_sub:  o_result = op_a - alu_b;
            rv_pkg::alu_sll:  o_result = op_a << alu_b[4:0];
            rv_pkg::alu_slt:  o_result[0] = $signed(op_a) < $signed(alu_b);
            rv_pkg::alu_sltu: o_result[0] = op_a < alu_b;
            rv_pkg::alu_xor:  o_result = op_a ^ alu_b;
            rv_pkg::alu_srl:  o_result = op_a >> alu_b[4:0];
            rv_pkg::alu_sra:  o_result = $signed(op_a) >>> alu_b[4:0];
            rv_pkg::alu_or:   o_result = op_a | alu_b;
            rv_pkg::alu_and:  o_result = op_a & alu_b;
            default:          o_result = op_a + alu_b;
        endcase
    end

    // Branch compare on forwarded registers, never on the immediate
    always_comb begin
        case (i_ctrl.br_op)
            rv_pkg::br_eq:  cmp_hit = op_a == op_b;
            rv_pkg::br_ne:  cmp_hit = op_a != op_b;
            rv_pkg::br_lt:  cmp_hit = $signed(op_a) < $signed(op_b);
            rv_pkg::br_ge:  cmp_hit = $signed(op_a) >= $signed(op_b);
            rv_pkg::br_ltu: cmp_hit = op_a < op_b;
            rv_pkg::br_geu: cmp_hit = op_a >= op_b;
            default:        cmp_hit = 1'b0;
        endcase
    end

    assign o_taken      = i_ctrl.branch && cmp_hit;
    assign o_target     = i_pc + i_imm;
    assign o_store_data = op_b;

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_we,
    input  logic [`RV_REG_W-1:0] i_waddr,
    input  logic [`RV_XLEN-1:0]  i_wdata,
    input  logic [`RV_REG_W-1:0] i_raddr_a,
    input  logic [`RV_REG_W-1:0] i_raddr_b,
    output logic [`RV_XLEN-1:0]  o_rdata_a,
    output logic [`RV_XLEN-1:0]  o_rdata_b
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // x0 reads zero, a write in flight is seen at once
    assign o_rdata_a = (i_raddr_a == '0) ? '0 :
                       (i_we && i_raddr_a == i_waddr) ? i_wdata : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 :
                       (i_we && i_raddr_b == i_waddr) ? i_wdata : regs[i_raddr_b];

endmodule

/* design/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode (
    input  logic [`RV_XLEN-1:0]  i_instr,
    output rv_pkg::ctrl_t        o_ctrl,
    output logic [`RV_REG_W-1:0] o_rs1,
    output logic [`RV_REG_W-1:0] o_rs2,
    output logic [`RV_REG_W-1:0] o_rd,
    output logic [`RV_XLEN-1:0]  o_imm
);

    rv_pkg::opcode_e     opcode;
    logic [2:0]          funct3;
    logic                f7_alt;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;

    assign opcode = rv_pkg::opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign f7_alt = i_instr[30];

    assign o_rs1 = i_instr[19:15];
    assign o_rs2 = i_instr[24:20];
    assign o_rd  = i_instr[11:7];

    // Sign extended immediates by format
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};

    always_comb begin
        o_ctrl = '0;
        o_imm  = imm_i;
        case (opcode)
            rv_pkg::op_lui: begin
                o_ctrl.wb_sel    = rv_pkg::wb_imm;
                o_ctrl.reg_write = 1'b1;
                o_imm            = imm_u;
            end
            rv_pkg::op_imm: begin
                // Only SRAI carries the funct7 alternate bit
                o_ctrl.alu_op    = rv_pkg::alu_op_e'({(funct3 == 3'b101) && f7_alt, funct3});
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.uses_rs1  = 1'b1;
            end
            rv_pkg::op_reg: begin
                o_ctrl.alu_op    = rv_pkg::alu_op_e'({(funct3 == 3'b000 || funct3 == 3'b101)
                                                      && f7_alt, funct3});
                o_ctrl.reg_write = 1'b1;
                o_ctrl.uses_rs1  = 1'b1;
                o_ctrl.uses_rs2  = 1'b1;
            end
            rv_pkg::op_load: begin
                // Word access only
                if (funct3 == 3'b010) begin
                    o_ctrl.use_imm   = 1'b1;
                    o_ctrl.mem_read  = 1'b1;
                    o_ctrl.wb_sel    = rv_pkg::wb_load;
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.uses_rs1  = 1'b1;
                end
            end
            rv_pkg::op_store: begin
                if (funct3 == 3'b010) begin
                    o_ctrl.use_imm   = 1'b1;
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.uses_rs1  = 1'b1;
                    o_ctrl.uses_rs2  = 1'b1;
                end
                o_imm = imm_s;
            end
            rv_pkg::op_branch: begin
                // funct3 010 and 011 are reserved
                if (funct3[2:1] != 2'b01) begin
                    o_ctrl.branch   = 1'b1;
                    o_ctrl.br_op    = rv_pkg::br_op_e'(funct3);
                    o_ctrl.uses_rs1 = 1'b1;
                    o_ctrl.uses_rs2 = 1'b1;
                end
                o_imm = imm_b;
            end
            default: ;
        endcase
    end

    a_rw_excl: assert final (!(o_ctrl.mem_read && o_ctrl.mem_write));

endmodule

/* design/rv_fwd_if.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

interface rv_fwd_if;

    // Producer sitting in MEM
    logic [`RV_REG_W-1:0] mem_rd;
    logic                 mem_wr;
    logic                 mem_is_load;
    logic [`RV_XLEN-1:0]  mem_value;

    // Producer sitting in WB
    logic [`RV_REG_W-1:0] wb_rd;
    logic                 wb_wr;
    logic [`RV_XLEN-1:0]  wb_value;

    modport src (
        output mem_rd, mem_wr, mem_is_load, mem_value,
        output wb_rd, wb_wr, wb_value
    );

    modport exe (
        input mem_rd, mem_wr, mem_is_load, mem_value,
        input wb_rd, wb_wr, wb_value
    );

endinterface

/* design/rv_pkg.sv */
package rv_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    // Bit 3 mirrors funct7[5], bits 2:0 mirror funct3
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    // Same encoding as the branch funct3
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } br_op_e;

    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_load = 2'd1,
        wb_imm  = 2'd2
    } wb_sel_e;

    // All zero is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    branch;
        br_op_e  br_op;
        logic    mem_read;
        logic    mem_write;
        wb_sel_e wb_sel;
        logic    reg_write;
        logic    uses_rs1;
        logic    uses_rs2;
    } ctrl_t;

endpackage

/* design/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register file
`define RV_NREGS 32
`define RV_REG_W 5

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif
